/* logic/rsc_dec_llr_pkg.sv */
package rsc_dec_llr_pkg;

  //------------------------------------------------------------
  // soft value widths
  //------------------------------------------------------------

  parameter int LLR_W = 5;  // signed llr, range -16..+15

  typedef logic signed [LLR_W-1 : 0] llr_t;

  // duo-bit pair, bit 0 sits in the low half
  typedef llr_t [1 : 0] dbit_llr_t;

  //------------------------------------------------------------
  // per path data words
  //------------------------------------------------------------

  // one path input word
  typedef struct packed {
    dbit_llr_t s_llr;   // channel systematic llr
    dbit_llr_t lextr;   // extrinsic from the other decoder
  } path_in_t;

  // one path output word
  typedef struct packed {
    dbit_llr_t    lextr;  // new extrinsic
    logic [1 : 0] dat;    // hard decision
    logic [1 : 0] derr;   // decision vs channel sign
  } path_out_t;

endpackage

/* logic/rsc_dec_ctrl_pkg.sv */
package rsc_dec_ctrl_pkg;

  //------------------------------------------------------------
  // widths and latency
  //------------------------------------------------------------

  parameter int ADDR_W     = 8;
  parameter int DTAG_W     = 8;   // duo-bit tag, multichannel modes
  parameter int ERR_W      = 16;
  parameter int PATH_DELAY = 3;   // soft path latency, enabled cycles

  typedef logic [ADDR_W-1 : 0] addr_t;
  typedef logic [DTAG_W-1 : 0] dtag_t;
  typedef logic [ERR_W-1  : 0] err_cnt_t;

  //------------------------------------------------------------
  // word control and sub-iteration mode
  //------------------------------------------------------------

  typedef struct packed {
    logic sop;
    logic val;
    logic eop;
    logic last;   // word of the last sub-iteration
  } word_ctrl_t;

  typedef struct packed {
    logic first;    // first sub-iteration, no a priori yet
    logic even;     // 1 natural order, 0 permuted
    logic bitswap;  // swap the bit pair
  } iter_mode_t;

  // word identity, travels with the data
  typedef struct packed {
    addr_t faddr;
    addr_t baddr;
    dtag_t fdtag;
    dtag_t bdtag;
  } word_id_t;

endpackage

/* logic/rsc_dec_ctrl_line.sv */
`timescale 1ns/1ps

module rsc_dec_ctrl_line #(
  parameter int p_delay = 3  // stages, equals soft path latency
) (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  rsc_dec_ctrl_pkg::word_ctrl_t ctrl,
  input  rsc_dec_ctrl_pkg::word_id_t   id,
  output rsc_dec_ctrl_pkg::word_ctrl_t octrl,
  output rsc_dec_ctrl_pkg::word_id_t   oid
);

  import rsc_dec_ctrl_pkg::*;

  //------------------------------------------------------------
  // shift registers
  //------------------------------------------------------------

  logic [p_delay-1 : 0] val_q;   // only these see reset
  logic [p_delay-1 : 0] sop_q;
  logic [p_delay-1 : 0] eop_q;
  logic [p_delay-1 : 0] last_q;
  word_id_t             id_q [p_delay];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q <= '0;
    end
    else if (iclkena) begin
      val_q[0] <= ctrl.val;
      for (int i = 1; i < p_delay; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  // wide fields just follow the enable
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sop_q[0]  <= ctrl.sop;
      eop_q[0]  <= ctrl.eop;
      last_q[0] <= ctrl.last;
      id_q[0]   <= id;
      for (int i = 1; i < p_delay; i++) begin
        sop_q[i]  <= sop_q[i-1];
        eop_q[i]  <= eop_q[i-1];
        last_q[i] <= last_q[i-1];
        id_q[i]   <= id_q[i-1];
      end
    end
  end

  //------------------------------------------------------------
  // line tail
  //------------------------------------------------------------

  assign octrl.sop  = sop_q[p_delay-1];
  assign octrl.val  = val_q[p_delay-1];
  assign octrl.eop  = eop_q[p_delay-1];
  assign octrl.last = last_q[p_delay-1];
  assign oid        = id_q[p_delay-1];

endmodule

/* logic/rsc_dec_half_path.sv */
`timescale 1ns/1ps

module rsc_dec_half_path #(
  parameter bit p_b_nf = 0  // 1 for backward path, inverts swap sense
) (
  input  logic                         iclk,
  input  logic                         ireset,
  input  logic                         iclkena,
  input  logic                         ival,
  input  rsc_dec_ctrl_pkg::iter_mode_t mode,
  input  rsc_dec_llr_pkg::path_in_t    din,
  output logic                         oval,
  output rsc_dec_llr_pkg::path_out_t   dout
);

  import rsc_dec_llr_pkg::*;
  import rsc_dec_ctrl_pkg::*;

  typedef logic signed [LLR_W : 0] llr_ext_t;  // one guard bit

  // explicit sign extension by one bit
  function automatic llr_ext_t ext(input llr_t v);
    return {v[LLR_W-1], v};
  endfunction

  // clip back to llr range on overflow
  function automatic llr_t sat(input llr_ext_t v);
    llr_t res;
    if (v[LLR_W] != v[LLR_W-1]) begin
      res = v[LLR_W] ? {1'b1, {(LLR_W-1){1'b0}}}   // -16
                     : {1'b0, {(LLR_W-1){1'b1}}};  // +15
    end
    else begin
      res = v[LLR_W-1 : 0];
    end
    return res;
  endfunction

  logic       s1_val, s2_val;
  iter_mode_t s1_mode, s2_mode;
  dbit_llr_t  s1_sllr, s1_lapri;
  dbit_llr_t  s2_sllr, s2_lapo;
  logic [1:0] s2_dat, s2_derr;

  dbit_llr_t  lapo;       // stage 2 comb
  logic [1:0] dat, hd;
  dbit_llr_t  lextr;      // stage 3 comb
  logic       swap;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      oval   <= 1'b0;
    end
    else if (iclkena) begin
      s1_val <= ival;
      s2_val <= s1_val;
      oval   <= s2_val;
    end
  end

  //------------------------------------------------------------
  // stage 1, a priori gate
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      s1_mode  <= mode;
      s1_sllr  <= din.s_llr;
      s1_lapri <= mode.first ? '0 : din.lextr;  // nothing learned yet
    end
  end

  //------------------------------------------------------------
  // stage 2, a posteriori sum and decisions
  //------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      lapo[i] = sat(ext(s1_sllr[i]) + ext(s1_lapri[i]));
      dat[i]  = ~lapo[i][LLR_W-1];     // nonnegative -> 1
      hd[i]   = ~s1_sllr[i][LLR_W-1];  // channel only decision
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      s2_mode <= s1_mode;
      s2_sllr <= s1_sllr;
      s2_lapo <= lapo;
      s2_dat  <= dat;
      s2_derr <= dat ^ hd;
    end
  end

  //------------------------------------------------------------
  // stage 3, extrinsic and pair swap
  //------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      lextr[i] = sat(ext(s2_lapo[i]) - ext(s2_sllr[i]));
    end
  end

  // permuted sub-iteration only, backward sense inverted
  assign swap = ~s2_mode.even & (s2_mode.bitswap ^ p_b_nf);

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      dout.lextr <= swap ? {lextr[0], lextr[1]} : lextr;
      dout.dat   <= swap ? {s2_dat[0], s2_dat[1]} : s2_dat;
      dout.derr  <= swap ? {s2_derr[0], s2_derr[1]} : s2_derr;
    end
  end

endmodule

/* logic/rsc_dec_err_acc.sv */
`timescale 1ns/1ps

module rsc_dec_err_acc (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  rsc_dec_ctrl_pkg::word_ctrl_t ctrl,    // delayed control
  input  logic [1 : 0]                  f_derr,
  input  logic [1 : 0]                  b_derr,
  output rsc_dec_ctrl_pkg::err_cnt_t   oerr,
  output logic                          odone
);

  import rsc_dec_ctrl_pkg::*;

  //------------------------------------------------------------
  // per word error count, 0..4
  //------------------------------------------------------------

  logic [2 : 0] word_err;

  assign word_err = f_derr[0] + f_derr[1] + b_derr[0] + b_derr[1];

  //------------------------------------------------------------
  // running count and done
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oerr  <= '0;
      odone <= 1'b0;
    end
    else if (iclkena) begin
      // one pulse after last word of last sub-iteration
      odone <= ctrl.val & ctrl.eop & ctrl.last;
      if (ctrl.val) begin
        if (ctrl.sop) begin
          oerr <= err_cnt_t'(word_err);         // restart, sop word counts too
        end
        else begin
          oerr <= oerr + err_cnt_t'(word_err);  // wraps at ERR_W
        end
      end
    end
  end

endmodule

/* logic/rsc_dec_engine.sv */
`timescale 1ns/1ps

module rsc_dec_engine (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,   // only stall
  input  rsc_dec_ctrl_pkg::word_ctrl_t ctrl,
  input  rsc_dec_ctrl_pkg::iter_mode_t mode,      // sampled with each word
  input  rsc_dec_ctrl_pkg::word_id_t   id,
  input  rsc_dec_llr_pkg::path_in_t    f_in,
  input  rsc_dec_llr_pkg::path_in_t    b_in,
  output rsc_dec_ctrl_pkg::word_ctrl_t octrl,
  output rsc_dec_ctrl_pkg::word_id_t   oid,
  output rsc_dec_llr_pkg::path_out_t   f_out,
  output rsc_dec_llr_pkg::path_out_t   b_out,
  output rsc_dec_ctrl_pkg::err_cnt_t   oerr,
  output logic                          odone
);

  import rsc_dec_llr_pkg::*;
  import rsc_dec_ctrl_pkg::*;

  word_ctrl_t line_ctrl;  // delayed control
  logic       f_oval;

  //------------------------------------------------------------
  // control delay line
  //------------------------------------------------------------

  rsc_dec_ctrl_line #(
    .p_delay (PATH_DELAY)
  ) u_ctrl_line (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ctrl    (ctrl),
    .id      (id),
    .octrl   (line_ctrl),
    .oid     (oid)
  );

  //------------------------------------------------------------
  // forward and backward soft paths
  //------------------------------------------------------------

  rsc_dec_half_path #(
    .p_b_nf (1'b0)
  ) u_f_path (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ctrl.val),
    .mode    (mode),
    .din     (f_in),
    .oval    (f_oval),
    .dout    (f_out)
  );

  rsc_dec_half_path #(
    .p_b_nf (1'b1)
  ) u_b_path (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ctrl.val),
    .mode    (mode),
    .din     (b_in),
    .oval    (),          // same timing as forward
    .dout    (b_out)
  );

  // data valid comes from the forward path, framing from the line
  assign octrl.sop  = line_ctrl.sop;
  assign octrl.val  = f_oval;
  assign octrl.eop  = line_ctrl.eop;
  assign octrl.last = line_ctrl.last;

  //------------------------------------------------------------
  // error count and done
  //------------------------------------------------------------

  rsc_dec_err_acc u_err_acc (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ctrl    (line_ctrl),
    .f_derr  (f_out.derr),
    .b_derr  (b_out.derr),
    .oerr    (oerr),
    .odone   (odone)
  );

endmodule

/* bench/tb_rsc_dec_engine.sv */
`timescale 1ns/1ps

module tb_rsc_dec_engine;

  import rsc_dec_llr_pkg::*;
  import rsc_dec_ctrl_pkg::*;

  localparam int N_FRAMES    = 40;
  localparam int WAIT_LIMIT  = 64;   // cycles a word may wait for iclkena
  localparam int DRAIN_LIMIT = 32;

  // accepted word plus the enabled edge it entered on
  typedef struct packed {
    int         idx;
    word_ctrl_t ctrl;
    iter_mode_t mode;
    word_id_t   id;
    path_in_t   f_in;
    path_in_t   b_in;
  } word_rec_t;

  logic       iclk = 1'b0;
  logic       ireset;
  logic       iclkena;
  word_ctrl_t ctrl, octrl;
  iter_mode_t mode;
  word_id_t   id, oid;
  path_in_t   f_in, b_in;
  path_out_t  f_out, b_out;
  err_cnt_t   oerr;
  logic       odone;

  integer     seed = 95;
  int         err_cnt, en_cnt;
  word_rec_t  acc_q [$];
  word_rec_t  cap_word, rec;
  bit         cap_en;
  path_out_t  fo, bo;
  int         nerr;
  err_cnt_t   exp_err;
  err_cnt_t   pend_err = '0;  // oerr is zero out of reset
  bit         exp_done, pend_done;

  rsc_dec_engine uut (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .ctrl (ctrl), .mode (mode), .id (id), .f_in (f_in), .b_in (b_in),
    .octrl (octrl), .oid (oid), .f_out (f_out), .b_out (b_out),
    .oerr (oerr), .odone (odone)
  );

  always #20 iclk = ~iclk;  // 40 ns period

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic int clip_llr(input int v);
    int r;
    r = v;
    if (v > 15) r = 15;         // top of 5-bit range
    else if (v < -16) r = -16;
    return r;
  endfunction

  // reference path, straight from the soft-bit rules
  function automatic path_out_t model_path(input path_in_t din, input iter_mode_t m,
                                           input bit bwd);
    path_out_t r;
    int        s, a, p;
    bit        sw;
    for (int i = 0; i < 2; i++) begin
      s          = din.s_llr[i];
      a          = m.first ? 0 : int'(din.lextr[i]);  // no a priori on first pass
      p          = clip_llr(s + a);
      r.lextr[i] = llr_t'(clip_llr(p - s));
      r.dat[i]   = (p >= 0);
      r.derr[i]  = (p >= 0) != (s >= 0);
    end
    sw = !m.even && (bwd ? !m.bitswap : m.bitswap);  // permuted pass only
    if (sw) begin
      r.lextr = {r.lextr[0], r.lextr[1]};
      r.dat   = {r.dat[0], r.dat[1]};
      r.derr  = {r.derr[0], r.derr[1]};
    end
    return r;
  endfunction

  // extremes show up often, else any 5-bit value
  function automatic llr_t rand_llr();
    case ($random(seed) & 7)
      0:       return llr_t'(-16);
      1:       return llr_t'(15);
      2:       return llr_t'(-15);
      default: return llr_t'($random(seed));
    endcase
  endfunction

  // hold one word until an enabled edge takes it
  task automatic send_word(input word_ctrl_t c, input iter_mode_t m);
    int tries;
    bit taken;
    ctrl  = c;
    mode  = m;
    id    = word_id_t'($random(seed));
    f_in  = {rand_llr(), rand_llr(), rand_llr(), rand_llr()};
    b_in  = {rand_llr(), rand_llr(), rand_llr(), rand_llr()};
    tries = 0;
    taken = 0;
    while (!taken) begin
      iclkena = (($random(seed) & 3) != 0);  // low about 1 in 4
      @(posedge iclk);
      #1;
      taken = iclkena;
      tries++;
      if (!taken && tries >= WAIT_LIMIT)
        abort_run("timeout: clock enable stayed low while a word was waiting");
    end
  endtask

  //------------------------------------------------------------
  // monitor, mid-cycle so both sides are settled
  //------------------------------------------------------------

  always @(negedge iclk) begin
    if (cap_en) begin
      en_cnt++;
      if (cap_word.ctrl.val) begin
        cap_word.idx = en_cnt;
        acc_q.push_back(cap_word);
      end
      exp_err  = pend_err;   // counter lags the output by one enabled edge
      exp_done = pend_done;
      compare_val("oerr", 64'(oerr), 64'(exp_err));
      compare_val("odone", 64'(odone), 64'(exp_done));
      pend_err  = exp_err;
      pend_done = 1'b0;
      if (acc_q.size() != 0 && acc_q[0].idx + PATH_DELAY - 1 == en_cnt) begin
        rec = acc_q.pop_front();
        fo  = model_path(rec.f_in, rec.mode, 1'b0);
        bo  = model_path(rec.b_in, rec.mode, 1'b1);
        compare_val("octrl", 64'(octrl), 64'(rec.ctrl));
        compare_val("oid", 64'(oid), 64'(rec.id));
        compare_val("f_out", 64'(f_out), 64'(fo));
        compare_val("b_out", 64'(b_out), 64'(bo));
        nerr     = fo.derr[0] + fo.derr[1] + bo.derr[0] + bo.derr[1];
        pend_err = rec.ctrl.sop ? err_cnt_t'(nerr) : err_cnt_t'(exp_err + nerr);
        if (rec.ctrl.eop && rec.ctrl.last) begin
          pend_done = 1'b1;
        end
      end
      else begin
        compare_val("octrl.val", 64'(octrl.val), 64'(0));  // nothing due
      end
    end
    cap_en   = iclkena && !ireset;
    cap_word = '{idx: 0, ctrl: ctrl, mode: mode, id: id, f_in: f_in, b_in: b_in};
  end

  //------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------

  initial begin
    word_ctrl_t c;
    iter_mode_t m;
    int         len, tries;
    bit         last;
    ireset  = 1'b1;
    iclkena = 1'b0;
    ctrl    = '0;
    mode    = '0;
    id      = '0;
    f_in    = '0;
    b_in    = '0;
    repeat (3) @(posedge iclk);
    #1 ireset = 1'b0;
    compare_val("oerr after reset", 64'(oerr), 64'(0));
    compare_val("odone after reset", 64'(odone), 64'(0));
    compare_val("octrl.val after reset", 64'(octrl.val), 64'(0));

    for (int f = 0; f < N_FRAMES; f++) begin
      len       = 2 + ($random(seed) & 7);
      last      = (($random(seed) & 3) == 0) || (f == N_FRAMES - 1);
      m.first   = (($random(seed) & 3) == 0);
      m.even    = $random(seed) & 1;
      m.bitswap = $random(seed) & 1;
      for (int w = 0; w < len; w++) begin
        if (($random(seed) & 7) == 0) send_word('0, m);  // idle gap
        c = '{sop: (w == 0), val: 1'b1, eop: (w == len - 1), last: last};
        send_word(c, m);
      end
    end

    // flush the pipe, then let oerr and odone settle
    tries = 0;
    while (acc_q.size() != 0) begin
      send_word('0, '0);
      tries++;
      if (tries > DRAIN_LIMIT)
        abort_run("timeout: output words still missing after the input stopped");
    end
    repeat (3) send_word('0, '0);
    @(negedge iclk);

    if (err_cnt == 0) begin
      $display("** PASS **");
    end
    else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/rsc_dec_llr_pkg.sv
logic/rsc_dec_ctrl_pkg.sv
logic/rsc_dec_ctrl_line.sv
logic/rsc_dec_half_path.sv
logic/rsc_dec_err_acc.sv
logic/rsc_dec_engine.sv
bench/tb_rsc_dec_engine.sv

/* run.sh */
#!/bin/sh
# build and run the engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
  --top-module tb_rsc_dec_engine --Mdir obj_dir -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **'
